// File: Makefile
# Verilator build and run for the memory subsystem testbench
# override any variable on the command line, e.g. make run LOG=other.log

SIM      ?= verilator
TOP      ?= memSubsystemTb
LOG      ?= sim.log
FILELIST ?= project.f
BUILDDIR ?= obj_dir
SIMFLAGS ?= --binary --assert -j 0
RUNFLAGS ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -qF '** PASS **' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: dv/memSubsystemTb.sv
////////////////////////////////////////////////////////////
// testbench for the two-client memory subsystem
// rows of the step table run one at a time, each active
// client's done is awaited with its own timeout
// a fetch may start a few cycles after the data request
// expected data comes from a byte-wide shadow of memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module memSubsystemTb
   import memBusPkg::*;
();

   localparam int Timeout     = 200;
   localparam int RandomSteps = 48;

   typedef enum logic [1:0] {
      OpNone,
      OpRead,
      OpWrite
   } dataOp_t;

   // one table row: stimulus plus expected err flags
   // fetchDelay holds the fetch back by whole cycles
   typedef struct packed {
      dataOp_t     op;
      logic [15:0] dataAddr;
      logic [15:0] wdata;
      logic        fetchEn;
      logic [1:0]  fetchDelay;
      logic [15:0] fetchAddr;
      logic        dataErr;
      logic        fetchErr;
   } step_t;

   logic    clk = 1'b0;
   logic    rst;
   memReq_t fetchReq;
   memReq_t dataReq;
   memRsp_t fetchRsp;
   memRsp_t dataRsp;

   step_t      steps[$];
   logic [7:0] shadow [65536];
   int         seed     = 32'hee306ef4;
   int         checks   = 0;
   int         errors   = 0;
   int         timeouts = 0;
   int         assertFails;

   // 4 ns period
   always #2 clk = ~clk;

   memSubsystem #(
      .AddrWidth    (16),
      .StallPattern (32'h6b5a3c19)
   ) i_dut (
      .clk      (clk),
      .rst      (rst),
      .fetchReq (fetchReq),
      .dataReq  (dataReq),
      .fetchRsp (fetchRsp),
      .dataRsp  (dataRsp)
   );

   ////////////////////////////////////////////////////////////
   // reference model and table helpers
   ////////////////////////////////////////////////////////////

   // big-endian word, high byte at the even address
   function automatic logic [15:0] shadowWord(input logic [15:0] addr);
      return {shadow[{addr[15:1], 1'b0}], shadow[{addr[15:1], 1'b1}]};
   endfunction

   task automatic addStep(input dataOp_t op, input logic [15:0] dAddr,
                          input logic [15:0] wdata, input logic fEn,
                          input logic [15:0] fAddr, input logic dErr,
                          input logic fErr, input logic [1:0] fDelay);
      step_t s;
      s.op         = op;
      s.dataAddr   = dAddr;
      s.wdata      = wdata;
      s.fetchEn    = fEn;
      s.fetchDelay = fDelay;
      s.fetchAddr  = fAddr;
      s.dataErr    = dErr;
      s.fetchErr   = fErr;
      steps.push_back(s);
   endtask

   task automatic driveDataReq(input step_t s);
      dataReq.rd    = (s.op == OpRead);
      dataReq.wr    = (s.op == OpWrite);
      dataReq.addr  = s.dataAddr;
      dataReq.wdata = s.wdata;
   endtask

   ////////////////////////////////////////////////////////////
   // per-client completion
   ////////////////////////////////////////////////////////////

   // sample 1 ns after the falling edge, request dropped on the
   // falling edge after done
   // a pending access that is not done must show stall
   task automatic awaitData(input step_t s);
      int          cycles;
      logic [15:0] expWord;
      if (s.op == OpNone) return;
      cycles = 0;
      #1;
      while (!dataRsp.done && cycles < Timeout) begin
         checks++;
         assert (dataRsp.stall) else begin
            $display("Mismatch at %0t: data %s addr %h pending without stall",
                     $time, s.op.name(), s.dataAddr);
            errors++;
         end
         @(negedge clk);
         #1;
         cycles++;
      end
      if (!dataRsp.done) begin
         $display("data %s at %h never completed within %0d cycles",
                  s.op.name(), s.dataAddr, Timeout);
         timeouts++;
      end else begin
         // writes return zero data
         expWord = (s.op == OpRead) ? shadowWord(s.dataAddr) : 16'h0000;
         checks++;
         assert (dataRsp.err == s.dataErr && dataRsp.rdata == expWord) else begin
            $display("Mismatch at %0t: data %s addr %h got %h err %b, expected %h err %b",
                     $time, s.op.name(), s.dataAddr, dataRsp.rdata, dataRsp.err,
                     expWord, s.dataErr);
            errors++;
         end
         // accepted aligned write lands in the shadow
         if (s.op == OpWrite && !s.dataAddr[0]) begin
            shadow[{s.dataAddr[15:1], 1'b0}] = s.wdata[15:8];
            shadow[{s.dataAddr[15:1], 1'b1}] = s.wdata[7:0];
         end
      end
      @(negedge clk);
      dataReq = '0;
   endtask

   // fetch goes up after its delay, so it can arrive while the
   // data client already owns a stalled bus
   task automatic runFetch(input step_t s);
      int          cycles;
      logic [15:0] expWord;
      if (!s.fetchEn) return;
      repeat (s.fetchDelay) @(negedge clk);
      fetchReq.rd    = 1'b1;
      fetchReq.wr    = 1'b0;
      fetchReq.addr  = s.fetchAddr;
      fetchReq.wdata = 16'h0000;
      cycles = 0;
      #1;
      while (!fetchRsp.done && cycles < Timeout) begin
         checks++;
         assert (fetchRsp.stall) else begin
            $display("Mismatch at %0t: fetch addr %h pending without stall",
                     $time, s.fetchAddr);
            errors++;
         end
         @(negedge clk);
         #1;
         cycles++;
      end
      if (!fetchRsp.done) begin
         $display("fetch read at %h never completed within %0d cycles",
                  s.fetchAddr, Timeout);
         timeouts++;
      end else begin
         expWord = shadowWord(s.fetchAddr);
         checks++;
         assert (fetchRsp.err == s.fetchErr && fetchRsp.rdata == expWord) else begin
            $display("Mismatch at %0t: fetch addr %h got %h err %b, expected %h err %b",
                     $time, s.fetchAddr, fetchRsp.rdata, fetchRsp.err,
                     expWord, s.fetchErr);
            errors++;
         end
      end
      @(negedge clk);
      fetchReq = '0;
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int          r;
      dataOp_t     op;
      logic [15:0] dAddr;
      logic [15:0] fAddr;
      rst      = 1'b1;
      fetchReq = '0;
      dataReq  = '0;
      shadow   = '{default: 8'h00};

      // fresh memory reads as zero from both clients
      addStep(OpRead, 16'h0000, 16'h0000, 1'b1, 16'h0002, 1'b0, 1'b0, 2'd0);
      addStep(OpRead, 16'h1234, 16'h0000, 1'b1, 16'hfffe, 1'b0, 1'b0, 2'd0);
      addStep(OpNone, 16'h0000, 16'h0000, 1'b1, 16'h8000, 1'b0, 1'b0, 2'd0);
      // write then read back from both sides
      addStep(OpWrite, 16'h0040, 16'ha55a, 1'b0, 16'h0000, 1'b0, 1'b0, 2'd0);
      addStep(OpRead, 16'h0040, 16'h0000, 1'b1, 16'h0040, 1'b0, 1'b0, 2'd0);
      // odd write refused, odd read gives the aligned word
      addStep(OpWrite, 16'h0041, 16'h1234, 1'b0, 16'h0000, 1'b1, 1'b0, 2'd0);
      addStep(OpRead, 16'h0041, 16'h0000, 1'b1, 16'h0040, 1'b1, 1'b0, 2'd0);
      // both clients every row, same words
      for (int i = 0; i < 8; i++) begin
         addStep(OpWrite, 16'h0100 + 16'(2 * i), 16'h0f0f ^ 16'(i), 1'b1,
                 16'h0100 + 16'(2 * i), 1'b0, 1'b0, 2'd0);
      end
      // random aligned traffic in a small window so words get reused
      // fetch start is staggered to land inside data stalls
      for (int i = 0; i < RandomSteps; i++) begin
         r     = $random(seed);
         dAddr = {10'h008, r[5:1], 1'b0};
         fAddr = {10'h008, r[10:6], 1'b0};
         case (r[12:11])
            2'd0:    op = OpNone;
            2'd1:    op = OpRead;
            default: op = OpWrite;
         endcase
         addStep(op, dAddr, r[31:16], r[13] | (op == OpNone), fAddr, 1'b0, 1'b0,
                 r[15:14]);
      end

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // no request means all response flags low
      #1;
      checks++;
      assert (fetchRsp == '0 && dataRsp == '0) else begin
         $display("Mismatch at %0t: idle responses not zero, fetch %h data %h",
                  $time, fetchRsp, dataRsp);
         errors++;
      end

      foreach (steps[i]) begin
         @(negedge clk);
         driveDataReq(steps[i]);
         fork
            awaitData(steps[i]);
            runFetch(steps[i]);
         join
      end

      assertFails = i_dut.i_arbiter.i_assertions.failCount;
      $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
               checks, errors, timeouts, assertFails);
      if (errors == 0 && timeouts == 0 && assertFails == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: dv/memSubsystem_assertions.sv
////////////////////////////////////////////////////////////
// concurrent checks on the two-client memory arbiter
// bound into every memArbiter instance
// failCount is read back by the testbench at the end
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module memSubsystem_assertions
   import memBusPkg::*;
   import memArbPkg::*;
(
   input logic      clk,
   input logic      rst,
   input memRsp_t   fetchRsp,
   input memRsp_t   dataRsp,
   input memRsp_t   busRsp,
   input clientId_t grant
);

   int failCount = 0;

   // one bus, so at most one client is served per cycle
   noDoubleDone: assert property (@(posedge clk) disable iff (rst)
      !(fetchRsp.done && dataRsp.done))
   else begin
      $error("fetch and data both saw done in one cycle");
      failCount++;
   end

   // served and held off are exclusive on each response
   fetchDoneStall: assert property (@(posedge clk) disable iff (rst)
      !(fetchRsp.done && fetchRsp.stall))
   else begin
      $error("fetch response shows done and stall together");
      failCount++;
   end

   dataDoneStall: assert property (@(posedge clk) disable iff (rst)
      !(dataRsp.done && dataRsp.stall))
   else begin
      $error("data response shows done and stall together");
      failCount++;
   end

   // a stalled owner keeps the grant into the next cycle
   lockHolds: assert property (@(posedge clk) disable iff (rst)
      busRsp.stall |=> (grant == $past(grant)))
   else begin
      $error("grant moved away from a stalled owner");
      failCount++;
   end

endmodule

bind memArbiter memSubsystem_assertions i_assertions (
   .clk      (clk),
   .rst      (rst),
   .fetchRsp (fetchRsp),
   .dataRsp  (dataRsp),
   .busRsp   (busRsp),
   .grant    (grant)
);

// File: hdl/memArbPkg.sv
////////////////////////////////////////////////////////////
// arbiter enums for the shared memory bus
// two clients only: fetch (read only) and data
////////////////////////////////////////////////////////////

package memArbPkg;

   // owner of the memory bus
   typedef enum logic {
      ClientFetch,
      ClientData
   } clientId_t;

   // arbiter state
   // ArbOpen: a new grant may be picked this cycle
   // ArbLocked: a stalled owner holds the bus until done
   typedef enum logic {
      ArbOpen,
      ArbLocked
   } arbState_t;

endpackage

// File: hdl/memArbiter.sv
////////////////////////////////////////////////////////////
// two-client arbiter onto one stalling memory bus
// alternating priority on ties, chosen in the same cycle
// a stalled owner keeps the bus until its done
// fetch is read only, its wr and wdata are dropped
// clients must hold requests stable until done
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module memArbiter
   import memBusPkg::*;
   import memArbPkg::*;
#(
   parameter int AddrWidth = 16
) (
   input  logic    clk,
   input  logic    rst,
   input  memReq_t fetchReq,
   input  memReq_t dataReq,
   output memRsp_t fetchRsp,
   output memRsp_t dataRsp,
   output memReq_t busReq,
   input  memRsp_t busRsp
);

   // keeps only the address bits the memory decodes
   localparam logic [BusAddrWidth-1:0] AddrMask =
      BusAddrWidth'((64'd1 << AddrWidth) - 64'd1);

   // control state
   arbState_t state;
   clientId_t lockOwner;
   clientId_t lastServed;

   // this cycle's decisions
   logic      fetchPend;
   logic      dataPend;
   clientId_t grant;
   memReq_t   fetchClean;
   memReq_t   dataClean;

   ////////////////////////////////////////////////////////////
   // request cleanup and grant
   ////////////////////////////////////////////////////////////

   // fetch only ever reads
   assign fetchPend = fetchReq.rd;
   assign dataPend  = dataReq.rd | dataReq.wr;

   always_comb begin
      fetchClean.rd    = fetchReq.rd;
      fetchClean.wr    = 1'b0;
      fetchClean.addr  = fetchReq.addr & AddrMask;
      fetchClean.wdata = '0;
   end

   always_comb begin
      dataClean      = dataReq;
      dataClean.addr = dataReq.addr & AddrMask;
   end

   // locked owner first, then the client not served last
   // default grant is fetch, harmless when nobody asks
   always_comb begin
      if (state == ArbLocked) begin
         grant = lockOwner;
      end else if (fetchPend && dataPend) begin
         grant = (lastServed == ClientData) ? ClientFetch : ClientData;
      end else if (dataPend) begin
         grant = ClientData;
      end else begin
         grant = ClientFetch;
      end
   end

   // owner's request goes straight through
   assign busReq = (grant == ClientFetch) ? fetchClean : dataClean;

   ////////////////////////////////////////////////////////////
   // response routing
   ////////////////////////////////////////////////////////////

   // owner sees the bus response as is
   // a waiting loser only sees stall
   always_comb begin
      if (grant == ClientFetch) begin
         fetchRsp = busRsp;
      end else begin
         fetchRsp       = '0;
         fetchRsp.stall = fetchPend;
      end
   end

   always_comb begin
      if (grant == ClientData) begin
         dataRsp = busRsp;
      end else begin
         dataRsp       = '0;
         dataRsp.stall = dataPend;
      end
   end

   ////////////////////////////////////////////////////////////
   // lock and last-served tracking
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= ArbOpen;
         lockOwner  <= ClientFetch;
         // fetch wins the first tie
         lastServed <= ClientData;
      end else if (busRsp.done) begin
         // served, reopen for the next pick
         state      <= ArbOpen;
         lastServed <= grant;
      end else if (busRsp.stall) begin
         // held off, pin the bus to this client
         state     <= ArbLocked;
         lockOwner <= grant;
      end
   end

endmodule

// File: hdl/memBusPkg.sv
////////////////////////////////////////////////////////////
// shared memory bus types for the 16-bit teaching core
// words are 16 bits, big-endian, byte addressed
// addr field is always 16 bits wide; modules ignore the
// bits above their own AddrWidth parameter
////////////////////////////////////////////////////////////

package memBusPkg;

   // word width, fixed by the two-byte layout
   localparam int DataWidth = 16;

   // width of the addr field carried on the bus
   localparam int BusAddrWidth = 16;

   // request from a client or from the arbiter to memory
   // only one of rd and wr may be high at a time
   typedef struct packed {
      logic                    rd;
      logic                    wr;
      logic [BusAddrWidth-1:0] addr;
      logic [DataWidth-1:0]    wdata;
   } memReq_t;

   // response back to a client
   // rdata is zero unless this is a served read
   // done and stall are never high together
   typedef struct packed {
      logic [DataWidth-1:0] rdata;
      logic                 done;
      logic                 stall;
      logic                 err;
   } memRsp_t;

endpackage

// File: hdl/memSubsystem.sv
////////////////////////////////////////////////////////////
// memory side of the teaching core
// fetch and data clients share one stalling memory
// latency depends on StallPattern and on contention
// all ones pattern means no stalls at all
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module memSubsystem
   import memBusPkg::*;
#(
   parameter int          AddrWidth    = 16,
   parameter logic [31:0] StallPattern = 32'hffff_ffff
) (
   input  logic    clk,
   input  logic    rst,
   input  memReq_t fetchReq,
   input  memReq_t dataReq,
   output memRsp_t fetchRsp,
   output memRsp_t dataRsp
);

   // single shared bus between arbiter and memory
   memReq_t memBusReq;
   memRsp_t memBusRsp;

   // picks one client per cycle and routes answers back
   memArbiter #(
      .AddrWidth (AddrWidth)
   ) i_arbiter (
      .clk      (clk),
      .rst      (rst),
      .fetchReq (fetchReq),
      .dataReq  (dataReq),
      .fetchRsp (fetchRsp),
      .dataRsp  (dataRsp),
      .busReq   (memBusReq),
      .busRsp   (memBusRsp)
   );

   // byte array with the rotating stall pattern
   stallMem #(
      .AddrWidth    (AddrWidth),
      .StallPattern (StallPattern)
   ) i_mem (
      .clk    (clk),
      .rst    (rst),
      .busReq (memBusReq),
      .busRsp (memBusRsp)
   );

endmodule

// File: hdl/stallMem.sv
////////////////////////////////////////////////////////////
// byte-addressable stalling memory, 16-bit big-endian words
// aligned accesses only; odd addr gives err and no write
// reads are combinational in the cycle done is high
// writes commit on the clock edge of that cycle
// needs AddrWidth >= 2; contents power up as zero
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stallMem
   import memBusPkg::*;
#(
   parameter int          AddrWidth    = 16,
   parameter logic [31:0] StallPattern = 32'hffff_ffff
) (
   input  logic    clk,
   input  logic    rst,
   input  memReq_t busReq,
   output memRsp_t busRsp
);

   localparam int Depth = 1 << AddrWidth;

   ////////////////////////////////////////////////////////////
   // storage and stall pattern
   ////////////////////////////////////////////////////////////

   // one byte per address
   logic [7:0] mem [Depth];

   // rotating pattern, bit zero decides this cycle
   logic [31:0] pattern;

   // access decode
   logic                 pending;
   logic                 ready;
   logic                 alignErr;
   logic [AddrWidth-1:0] hiAddr;
   logic [AddrWidth-1:0] loAddr;
   logic [DataWidth-1:0] rdWord;
   logic                 wrEn;

   // memory starts cleared, no reset on the array
   initial begin
      for (int i = 0; i < Depth; i++) begin
         mem[i] = '0;
      end
   end

   // rotate right by one each cycle, reload in reset
   always_ff @(posedge clk) begin
      if (rst) begin
         pattern <= StallPattern;
      end else begin
         pattern <= {pattern[0], pattern[31:1]};
      end
   end

   ////////////////////////////////////////////////////////////
   // address and handshake decode
   ////////////////////////////////////////////////////////////

   // an access is pending whenever either strobe is up
   assign pending = busReq.rd | busReq.wr;

   // served only when the pattern allows it
   assign ready = pending & pattern[0];

   // odd byte address is illegal, flagged only when served
   assign alignErr = ready & busReq.addr[0];

   // high byte at the even address, low byte just above
   // an odd address falls back to the aligned pair holding it
   assign hiAddr = {busReq.addr[AddrWidth-1:1], 1'b0};
   assign loAddr = {busReq.addr[AddrWidth-1:1], 1'b1};

   assign rdWord = {mem[hiAddr], mem[loAddr]};

   // writes need ready and an even address
   assign wrEn = ready & busReq.wr & ~alignErr;

   ////////////////////////////////////////////////////////////
   // response
   ////////////////////////////////////////////////////////////

   always_comb begin
      busRsp.done  = ready;
      busRsp.stall = pending & ~pattern[0];
      busRsp.err   = alignErr;
      // data only on a served read, zero otherwise
      if (ready && !busReq.wr) begin
         busRsp.rdata = rdWord;
      end else begin
         busRsp.rdata = '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // write port
   ////////////////////////////////////////////////////////////

   // both bytes land on the same edge
   // visible to reads from the next cycle on
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[hiAddr] <= busReq.wdata[15:8];
         mem[loAddr] <= busReq.wdata[7:0];
      end
   end

endmodule

// File: project.f
hdl/memBusPkg.sv
hdl/memArbPkg.sv
hdl/stallMem.sv
hdl/memArbiter.sv
hdl/memSubsystem.sv
dv/memSubsystem_assertions.sv
dv/memSubsystemTb.sv
